//--- lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// width of one data word on the bus and at the requester port
`define LSU_DATA_WIDTH 32

// byte address width
`define LSU_ADDR_WIDTH 32

// sram depth in words, kept a power of two so the range check is a
// test of the upper index bits
`define LSU_MEM_WORDS 256

`endif

//--- lsu_pkg.sv
`default_nettype none
`include "lsu_macros.svh"

package lsu_pkg;

    // load/store operations seen at the requester port
    typedef enum logic [3:0]
    {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_op_t;

    // request as captured by the lsu when req is sampled
    typedef struct packed
    {
        lsu_op_t                     op;
        logic [`LSU_ADDR_WIDTH-1:0]  addr;
        logic [`LSU_DATA_WIDTH-1:0]  wdata;
    } lsu_req_t;

    // response held for the requester while ack is high
    typedef struct packed
    {
        logic [`LSU_DATA_WIDTH-1:0]  rdata;
        logic                        err;
    } lsu_rsp_t;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none
`include "lsu_macros.svh"

package axi_pkg;

    // two-bit bresp/rresp code
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t OKAY   = 2'b00;
    localparam axi_resp_t SLVERR = 2'b10;

    // one strobe bit per data byte
    typedef logic [`LSU_DATA_WIDTH/8-1:0] axi_strb_t;

endpackage

`default_nettype wire

//--- axi_lite_if.sv
`default_nettype none
`include "lsu_macros.svh"

interface axi_lite_if;

    import axi_pkg::*;

    // write address channel
    logic [`LSU_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;

    // write data channel
    logic [`LSU_DATA_WIDTH-1:0] wdata;
    axi_strb_t                  wstrb;
    logic                       wvalid;
    logic                       wready;

    // write response channel
    axi_resp_t                  bresp;
    logic                       bvalid;
    logic                       bready;

    // read address channel
    logic [`LSU_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    logic                       arready;

    // read data channel
    logic [`LSU_DATA_WIDTH-1:0] rdata;
    axi_resp_t                  rresp;
    logic                       rvalid;
    logic                       rready;

    // master owns valids, addresses, write payload and the response readies
    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    // slave owns the address/data readies and both response channels
    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

//--- lsu_axi_master.sv
`default_nettype none
`include "lsu_macros.svh"

module lsu_axi_master (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       req,
    input  lsu_pkg::lsu_op_t           op,
    input  logic [`LSU_ADDR_WIDTH-1:0] addr,
    input  logic [`LSU_DATA_WIDTH-1:0] wdata,
    output logic                       ack,
    output logic [`LSU_DATA_WIDTH-1:0] rdata,
    output logic                       err,
    axi_lite_if.master                 bus
);

    import lsu_pkg::*;
    import axi_pkg::*;

    localparam int DW = `LSU_DATA_WIDTH;

    typedef enum logic [1:0]
    {
        IDLE,
        ADDR,
        RESP,
        DONE
    } state_t;

    state_t          state;
    lsu_req_t        req_q;
    lsu_rsp_t        rsp_q;
    logic [2:0]      size_m1;
    logic            misaligned;
    logic [1:0]      lane;
    logic [DW-1:0]   rshift;
    logic [DW-1:0]   load_data;
    logic            aw_done;
    logic            w_done;
    logic            ar_done;

    // ------------------------------------------------------------------
    // op decode
    // ------------------------------------------------------------------

    function automatic logic is_store(input lsu_op_t o);
        return (o == SB) || (o == SH) || (o == SW);
    endfunction

    // access size in bytes
    function automatic logic [2:0] acc_size(input lsu_op_t o);
        case (o)
            LB, LBU, SB: return 3'd1;
            LH, LHU, SH: return 3'd2;
            default:     return 3'd4;
        endcase
    endfunction

    // strobe pattern before the lane shift
    function automatic axi_strb_t strb_mask(input lsu_op_t o);
        case (acc_size(o))
            3'd1:    return axi_strb_t'(4'b0001);
            3'd2:    return axi_strb_t'(4'b0011);
            default: return axi_strb_t'(4'b1111);
        endcase
    endfunction

    // any low address bit inside the access size means misaligned
    assign size_m1    = acc_size(op) - 3'd1;
    assign misaligned = |(addr[1:0] & size_m1[1:0]);

    // ------------------------------------------------------------------
    // bus side formatting, all from the captured request
    // ------------------------------------------------------------------

    assign lane       = req_q.addr[1:0];
    assign bus.awaddr = req_q.addr;
    assign bus.araddr = req_q.addr;

    // store data moves up onto the addressed lanes
    assign bus.wdata  = req_q.wdata << {lane, 3'b000};
    assign bus.wstrb  = strb_mask(req_q.op) << lane;

    // no back-pressure on b or r while waiting for the response
    assign bus.bready = (state == RESP) && is_store(req_q.op);
    assign bus.rready = (state == RESP) && !is_store(req_q.op);

    // load lane moves down to bit 0, then gets extended
    always_comb
    begin
        rshift = bus.rdata >> {lane, 3'b000};
        case (req_q.op)
            LB:      load_data = {{(DW-8){rshift[7]}}, rshift[7:0]};
            LH:      load_data = {{(DW-16){rshift[15]}}, rshift[15:0]};
            LBU:     load_data = {{(DW-8){1'b0}}, rshift[7:0]};
            LHU:     load_data = {{(DW-16){1'b0}}, rshift[15:0]};
            default: load_data = rshift;
        endcase
    end

    // a channel counts as done once its valid is low or being taken
    assign aw_done = !bus.awvalid || bus.awready;
    assign w_done  = !bus.wvalid || bus.wready;
    assign ar_done = !bus.arvalid || bus.arready;

    // ------------------------------------------------------------------
    // request capture and fsm
    // ------------------------------------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (state == IDLE && req)
            req_q <= '{op: op, addr: addr, wdata: wdata};
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state       <= IDLE;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.arvalid <= 1'b0;
            rsp_q       <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req && misaligned)
                    begin
                        // rejected without any bus traffic
                        rsp_q <= '{rdata: '0, err: 1'b1};
                        state <= DONE;
                    end
                    else if (req)
                    begin
                        bus.awvalid <= is_store(op);
                        bus.wvalid  <= is_store(op);
                        bus.arvalid <= !is_store(op);
                        state       <= ADDR;
                    end
                end
                ADDR:
                begin
                    if (bus.awvalid && bus.awready)
                        bus.awvalid <= 1'b0;
                    if (bus.wvalid && bus.wready)
                        bus.wvalid <= 1'b0;
                    if (bus.arvalid && bus.arready)
                        bus.arvalid <= 1'b0;
                    if (aw_done && w_done && ar_done)
                        state <= RESP;
                end
                RESP:
                begin
                    if (bus.bvalid && bus.bready)
                    begin
                        rsp_q <= '{rdata: '0, err: bus.bresp != OKAY};
                        state <= DONE;
                    end
                    else if (bus.rvalid && bus.rready)
                    begin
                        rsp_q <= '{rdata: load_data, err: bus.rresp != OKAY};
                        state <= DONE;
                    end
                end
                default:
                begin
                    // hold ack until the requester lets go of req
                    if (!req)
                        state <= IDLE;
                end
            endcase
        end
    end

    assign ack   = (state == DONE);
    assign rdata = rsp_q.rdata;
    assign err   = rsp_q.err;

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // address valids stay up until the slave takes them
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.awvalid && !bus.awready |=> bus.awvalid)
    else $error("awvalid dropped before awready");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.arvalid && !bus.arready |=> bus.arvalid)
    else $error("arvalid dropped before arready");

    // four-phase rule, ack only falls after req has gone
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        ack && req |=> ack)
    else $error("ack fell while req was high");

endmodule

`default_nettype wire

//--- sram_axi_slave.sv
`default_nettype none
`include "lsu_macros.svh"

module sram_axi_slave (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    axi_lite_if.slave bus
);

    import axi_pkg::*;

    localparam int DW    = `LSU_DATA_WIDTH;
    localparam int AW    = `LSU_ADDR_WIDTH;
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    logic [DW-1:0]    mem [`LSU_MEM_WORDS];
    logic             aw_en;
    logic             wr_fire;
    logic             rd_fire;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_in_range;
    logic             rd_in_range;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------

    // word index drops the two byte bits
    assign wr_idx = bus.awaddr[IDX_W+1:2];
    assign rd_idx = bus.araddr[IDX_W+1:2];

    // anything above the index bits means past the end of the array
    assign wr_in_range = (bus.awaddr[AW-1:IDX_W+2] == '0);
    assign rd_in_range = (bus.araddr[AW-1:IDX_W+2] == '0);

    // both write channels taken in the same cycle
    assign wr_fire = bus.awready && bus.awvalid && bus.wready && bus.wvalid
                     && !bus.bvalid;
    assign rd_fire = bus.arready && bus.arvalid && !bus.rvalid;

    // ------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bus.awready <= 1'b0;
            aw_en       <= 1'b1;
        end
        else if (!bus.awready && bus.awvalid && bus.wvalid && aw_en)
        begin
            // one write at a time, aw_en stays low until b is accepted
            bus.awready <= 1'b1;
            aw_en       <= 1'b0;
        end
        else if (bus.bready && bus.bvalid)
        begin
            bus.awready <= 1'b0;
            aw_en       <= 1'b1;
        end
        else
        begin
            bus.awready <= 1'b0;
        end
    end

    // wready pulses alongside awready
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
            bus.wready <= 1'b0;
        else
            bus.wready <= !bus.wready && bus.wvalid && bus.awvalid && aw_en;
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bus.bvalid <= 1'b0;
            bus.bresp  <= OKAY;
        end
        else if (wr_fire)
        begin
            bus.bvalid <= 1'b1;
            if (wr_in_range)
                bus.bresp <= OKAY;
            else
                bus.bresp <= SLVERR;
        end
        else if (bus.bvalid && bus.bready)
        begin
            bus.bvalid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
            bus.arready <= 1'b0;
        else
            bus.arready <= !bus.arready && bus.arvalid && !bus.rvalid;
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bus.rvalid <= 1'b0;
            bus.rresp  <= OKAY;
        end
        else if (rd_fire)
        begin
            bus.rvalid <= 1'b1;
            if (rd_in_range)
                bus.rresp <= OKAY;
            else
                bus.rresp <= SLVERR;
        end
        else if (bus.rvalid && bus.rready)
        begin
            bus.rvalid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // array with byte strobes
    // ------------------------------------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        // out-of-range writes are dropped
        if (wr_fire && wr_in_range)
        begin
            for (int b = 0; b < DW/8; b++)
            begin
                if (bus.wstrb[b])
                    mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
        // read data registered on the ar handshake, zero when out of range
        if (rd_fire)
            bus.rdata <= rd_in_range ? mem[rd_idx] : '0;
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.bvalid && !bus.bready |=> bus.bvalid)
    else $error("bvalid fell without bready");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.rvalid && !bus.rready |=> bus.rvalid)
    else $error("rvalid fell without rready");

    // aw_en must keep a second write out while b is outstanding
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bus.bvalid |-> !bus.awready)
    else $error("awready raised with bvalid pending");

endmodule

`default_nettype wire

//--- lsu_mem_top.sv
`default_nettype none
`include "lsu_macros.svh"

module lsu_mem_top (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    // four-phase requester port
    input  logic                       req,
    input  lsu_pkg::lsu_op_t           op,
    input  logic [`LSU_ADDR_WIDTH-1:0] addr,
    input  logic [`LSU_DATA_WIDTH-1:0] wdata,
    output logic                       ack,
    output logic [`LSU_DATA_WIDTH-1:0] rdata,
    output logic                       err
);

    // single axi4-lite link between the lsu and the sram
    axi_lite_if axi_i ();

    lsu_axi_master lsu_axi_master_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (req),
        .op            (op),
        .addr          (addr),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .err           (err),
        .bus           (axi_i)
    );

    sram_axi_slave sram_axi_slave_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bus           (axi_i)
    );

endmodule

`default_nettype wire

//--- tb_lsu_mem.sv
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu_mem;

    import lsu_pkg::*;

    localparam int DW           = `LSU_DATA_WIDTH;
    localparam int AW           = `LSU_ADDR_WIDTH;
    localparam int MEM_BYTES    = `LSU_MEM_WORDS * 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 40;
    localparam int N_RANDOM     = 300;
    // bus round trip plus the longest hold and gap and some margin
    localparam int TXN_CYCLES   = 24;

    logic          S_AXI_ACLK;
    logic          S_AXI_ARESETN;
    logic          req;
    lsu_op_t       op;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic          ack;
    logic [DW-1:0] rdata;
    logic          err;

    // byte-wide copy of the sram contents
    logic [7:0]    shadow [MEM_BYTES];
    logic          exp_err;
    logic          exp_chk_rdata;
    logic [DW-1:0] exp_rdata;
    logic [31:0]   lfsr;
    int            value_errors;
    int            protocol_errors;

    lsu_mem_top lsu_mem_top_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (req),
        .op            (op),
        .addr          (addr),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .err           (err)
    );

    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // ------------------------------------------------------------------
    // checks on every rising ack
    // ------------------------------------------------------------------

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(ack) |-> err == exp_err)
    else
    begin
        value_errors++;
        $display("ERROR t=%0t err expected %0b actual %0b", $time, exp_err, err);
    end

    // rdata only compared for aligned loads
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(ack) && exp_chk_rdata |-> rdata == exp_rdata)
    else
    begin
        value_errors++;
        $display("ERROR t=%0t rdata expected %h actual %h", $time, exp_rdata, rdata);
    end

    // four-phase rule seen from the requester side
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(ack) |-> $past(req))
    else
    begin
        protocol_errors++;
        $display("ack rose at %0t while no req was pending", $time);
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $fell(ack) |-> !$past(req))
    else
    begin
        protocol_errors++;
        $display("ack fell at %0t while req was still high", $time);
    end

    // ------------------------------------------------------------------
    // reference model helpers
    // ------------------------------------------------------------------

    function automatic int op_bytes(input lsu_op_t o);
        case (o)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic is_write_op(input lsu_op_t o);
        return o inside {SB, SH, SW};
    endfunction

    // little-endian bytes from the shadow with zero above the access
    function automatic logic [DW-1:0] expected_load(input lsu_op_t o, input logic [AW-1:0] a);
        logic [DW-1:0] raw;
        int            n;
        n   = op_bytes(o);
        raw = '0;
        for (int k = 0; k < n; k++)
            raw[8*k +: 8] = shadow[int'(a) + k];
        case (o)
            LB:      return {{(DW-8){raw[7]}}, raw[7:0]};
            LH:      return {{(DW-16){raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // ------------------------------------------------------------------
    // one full four-phase cycle
    // ------------------------------------------------------------------

    task automatic access(input lsu_op_t o, input logic [AW-1:0] a, input logic [DW-1:0] d,
                          input int hold, input int gap);
        int   n;
        logic misaligned;
        logic in_range;
        n          = op_bytes(o);
        misaligned = (a % n) != 0;
        in_range   = a < AW'(MEM_BYTES);
        // expected response set up before req rises
        exp_err       = misaligned || !in_range;
        exp_chk_rdata = !is_write_op(o) && !misaligned;
        if (exp_chk_rdata && in_range)
            exp_rdata = expected_load(o, a);
        else
            exp_rdata = '0;
        @(negedge S_AXI_ACLK);
        op    = o;
        addr  = a;
        wdata = d;
        req   = 1'b1;
        do
            @(negedge S_AXI_ACLK);
        while (!ack);
        // shadow follows only stores that reached the array
        if (is_write_op(o) && !exp_err)
        begin
            for (int k = 0; k < n; k++)
                shadow[int'(a) + k] = d[8*k +: 8];
        end
        // holding req keeps ack up
        repeat (hold) @(negedge S_AXI_ACLK);
        req = 1'b0;
        do
            @(negedge S_AXI_ACLK);
        while (ack);
        repeat (gap) @(negedge S_AXI_ACLK);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge S_AXI_ACLK);
            assert (ack === 1'b0)
            else
            begin
                value_errors++;
                $display("ERROR t=%0t ack expected 0 actual %b", $time, ack);
            end
            assert (err === 1'b0)
            else
            begin
                value_errors++;
                $display("ERROR t=%0t err expected 0 actual %b", $time, err);
            end
            assert (rdata === '0)
            else
            begin
                value_errors++;
                $display("ERROR t=%0t rdata expected %h actual %h", $time, {DW{1'b0}}, rdata);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // test sequences
    // ------------------------------------------------------------------

    task automatic merge_and_extend();
        access(SW, 32'h20, 32'h1122_3344, 0, 0);
        access(SB, 32'h21, 32'h0000_0080, 1, 0);
        access(SH, 32'h22, 32'h0000_f00d, 0, 1);
        access(LW, 32'h20, '0, 0, 0);
        access(LB, 32'h21, '0, 0, 0);
        access(LBU, 32'h21, '0, 0, 0);
        access(LH, 32'h22, '0, 0, 0);
        access(LHU, 32'h22, '0, 2, 0);
        // low byte positive and low halfword negative
        access(LB, 32'h20, '0, 0, 0);
        access(LH, 32'h20, '0, 0, 0);
    endtask

    task automatic misaligned_accesses();
        access(SW, 32'h24, 32'hcafe_babe, 0, 0);
        access(LH, 32'h25, '0, 0, 0);
        access(LW, 32'h26, '0, 0, 0);
        access(SW, 32'h26, 32'h0bad_0bad, 0, 0);
        access(SH, 32'h27, 32'h0000_5555, 0, 0);
        access(LW, 32'h24, '0, 0, 0);
    endtask

    task automatic out_of_range_accesses();
        access(SW, AW'(MEM_BYTES - 4), 32'h600d_f00d, 0, 0);
        // words that the rejected stores would hit if the upper bits were ignored
        access(SW, 32'h0, 32'h1357_9bdf, 0, 0);
        access(SW, AW'(MEM_BYTES - 16), 32'h0ddb_a11a, 0, 0);
        access(SW, AW'(MEM_BYTES), 32'h1234_5678, 0, 0);
        access(LW, AW'(MEM_BYTES), '0, 0, 0);
        access(LBU, AW'(MEM_BYTES + 5), '0, 0, 0);
        access(SW, 32'hffff_fff0, 32'h8765_4321, 0, 0);
        access(LW, 32'hffff_fff0, '0, 0, 0);
        // last word and both aliased words keep their contents
        access(LW, AW'(MEM_BYTES - 4), '0, 0, 0);
        access(LW, 32'h0, '0, 0, 0);
        access(LW, AW'(MEM_BYTES - 16), '0, 0, 0);
    endtask

    task automatic random_traffic();
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [31:0] r_hold;
        logic [31:0] r_gap;
        // fill the window so loads never read unwritten bytes
        for (int w = 0; w < 8; w++)
        begin
            r_data = take_bits(32);
            access(SW, AW'(4 * w), r_data, 0, 0);
        end
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r_op   = take_bits(3);
            r_addr = take_bits(5);
            r_data = take_bits(32);
            r_hold = take_bits(2);
            r_gap  = take_bits(2);
            access(lsu_op_t'({1'b0, r_op[2:0]}), r_addr, r_data, int'(r_hold), int'(r_gap));
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------

    initial
    begin
        S_AXI_ARESETN   = 1'b0;
        req             = 1'b0;
        op              = LB;
        addr            = '0;
        wdata           = '0;
        exp_err         = 1'b0;
        exp_chk_rdata   = 1'b0;
        exp_rdata       = '0;
        lfsr            = 32'd73696;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (RESET_CYCLES) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        check_idle(5);
        access(SW, 32'h10, 32'hdead_beef, 0, 0);
        access(LW, 32'h10, '0, 0, 0);
        merge_and_extend();
        misaligned_accesses();
        out_of_range_accesses();
        random_traffic();
        repeat (4) @(negedge S_AXI_ACLK);
        $display("errors: value %0d protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (RESET_CYCLES + (N_DIRECTED + N_RANDOM) * TXN_CYCLES) @(posedge S_AXI_ACLK);
        $display("watchdog expired, the DUT stopped answering requests");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_mem.f
+incdir+.
lsu_pkg.sv
axi_pkg.sv
axi_lite_if.sv
lsu_axi_master.sv
sram_axi_slave.sv
lsu_mem_top.sv
tb_lsu_mem.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator and run, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_lsu_mem -f lsu_mem.f \
    && ./obj_dir/Vtb_lsu_mem > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
